// File: include/sha1_settings.svh
`ifndef SHA1_SETTINGS_SVH
`define SHA1_SETTINGS_SVH

// compression rounds and widths.
`define SHA1_ROUNDS   80
`define SHA1_WORD_W   32
`define SHA1_BLOCK_W  512

// round constants, one per group of twenty rounds.
`define SHA1_K0  32'h5a827999
`define SHA1_K1  32'h6ed9eba1
`define SHA1_K2  32'h8f1bbcdc
`define SHA1_K3  32'hca62c1d6

// initial hash values.
`define SHA1_H0  32'h67452301
`define SHA1_H1  32'hefcdab89
`define SHA1_H2  32'h98badcfe
`define SHA1_H3  32'h10325476
`define SHA1_H4  32'hc3d2e1f0

`endif

// File: src/sha1_pkg.sv
`default_nettype none

`include "sha1_settings.svh"

package sha1_pkg;

  // ==========================================================================
  // data types
  // ==========================================================================

  // one schedule or state word.
  typedef logic [`SHA1_WORD_W-1:0] word_t;

  // message block, word 0 in the top bits.
  typedef logic [`SHA1_BLOCK_W-1:0] block_t;

  // digest, H0 in the top bits.
  typedef logic [5*`SHA1_WORD_W-1:0] digest_t;

  // round index, 0 to 79.
  typedef logic [6:0] round_t;

  // ==========================================================================
  // controller states
  // ==========================================================================

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ROUNDS = 2'd1,
    FINISH = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/sha1_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sha1_settings.svh"

module sha1_ctrl (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             init,
  input  logic             next,
  output logic             start,
  output logic             first_block,
  output logic             round_en,
  output logic             update,
  output logic             ready,
  output logic             digest_valid,
  output sha1_pkg::round_t round_idx
);

  import sha1_pkg::*;

  ctrl_state_t state_reg;
  round_t      round_reg;
  logic        ready_reg;
  logic        valid_reg;

  // ==========================================================================
  // strobes
  // ==========================================================================

  // pulses while busy are dropped, init wins over next.
  assign start       = ready_reg & (init | next);
  assign first_block = ready_reg & init;

  assign round_en     = (state_reg == ROUNDS);
  assign update       = (state_reg == FINISH);
  assign round_idx    = round_reg;
  assign ready        = ready_reg;
  assign digest_valid = valid_reg;

  // ==========================================================================
  // state machine and round counter
  // ==========================================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_reg <= IDLE;
      round_reg <= '0;
      ready_reg <= 1'b1;
      valid_reg <= 1'b0;
    end
    else
    begin
      case (state_reg)
        IDLE:
        begin
          if (start)
          begin
            state_reg <= ROUNDS;
            round_reg <= '0;
            ready_reg <= 1'b0;
            if (init)
              valid_reg <= 1'b0;   // old digest no longer valid.
          end
        end

        ROUNDS:
        begin
          if (round_reg == round_t'(`SHA1_ROUNDS - 1))
            state_reg <= FINISH;
          else
            round_reg <= round_reg + 7'd1;
        end

        FINISH:
        begin
          state_reg <= IDLE;
          ready_reg <= 1'b1;
          valid_reg <= 1'b1;
        end

        default:
        begin
          state_reg <= IDLE;
        end
      endcase
    end
  end

  a_round_range : assert property (
    @(posedge clk) disable iff (!reset_n)
    (state_reg == ROUNDS) |-> (round_reg < `SHA1_ROUNDS)
  ) else $error("sha1_ctrl: round index out of range.");

  a_ready_idle : assert property (
    @(posedge clk) disable iff (!reset_n)
    ready_reg |-> (state_reg == IDLE)
  ) else $error("sha1_ctrl: ready outside IDLE.");

endmodule

`default_nettype wire

// File: src/sha1_w_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "sha1_settings.svh"

module sha1_w_mem (
  input  logic             clk,
  input  logic             reset_n,
  input  sha1_pkg::block_t block,
  input  logic             init,
  input  logic             next,
  output sha1_pkg::word_t  w
);

  import sha1_pkg::*;

  // ==========================================================================
  // window and round counter
  // ==========================================================================

  word_t  window [16];   // sliding window, oldest word at 0.
  round_t ctr_reg;

  word_t  w_xor;
  word_t  w_new;

  // ==========================================================================
  // schedule expansion
  // ==========================================================================

  always_comb
  begin
    w_xor = window[13] ^ window[8] ^ window[2] ^ window[0];
    w_new = {w_xor[`SHA1_WORD_W-2:0], w_xor[`SHA1_WORD_W-1]};   // rotl 1.
  end

  // first sixteen rounds read the block directly.
  always_comb
  begin
    if (ctr_reg < 7'd16)
      w = window[ctr_reg[3:0]];
    else
      w = w_new;
  end

  // ==========================================================================
  // window update
  // ==========================================================================

  always_ff @(posedge clk)
  begin
    if (init)
    begin
      for (int i = 0; i < 16; i++)
      begin
        window[i] <= block[`SHA1_BLOCK_W-1-i*`SHA1_WORD_W -: `SHA1_WORD_W];
      end
    end
    else if (next && (ctr_reg > 7'd15))
    begin
      // drop the oldest word, append the expanded one.
      for (int i = 0; i < 15; i++)
      begin
        window[i] <= window[i+1];
      end
      window[15] <= w_new;
    end
  end

  // ==========================================================================
  // round counter
  // ==========================================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ctr_reg <= '0;
    end
    else if (init)
    begin
      ctr_reg <= '0;
    end
    else if (next)
    begin
      ctr_reg <= ctr_reg + 7'd1;   // one word per round.
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  // block load and round advance come from different controller states.
  a_init_next_excl : assert property (
    @(posedge clk) disable iff (!reset_n)
    !(init && next)
  ) else $error("sha1_w_mem: init and next high together.");

  // a load is always followed by the first round word being consumed.
  a_init_then_next : assert property (
    @(posedge clk) disable iff (!reset_n)
    init |=> next
  ) else $error("sha1_w_mem: no round after block load.");

endmodule

`default_nettype wire

// File: src/sha1_compress.sv
`timescale 1ns/1ps
`default_nettype none

`include "sha1_settings.svh"

module sha1_compress (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              load,
  input  logic              first_block,
  input  logic              round_en,
  input  logic              update,
  input  sha1_pkg::round_t  round_idx,
  input  sha1_pkg::word_t   w,
  output sha1_pkg::digest_t digest
);

  import sha1_pkg::*;

  // ==========================================================================
  // working variables and chained digest
  // ==========================================================================

  word_t a_reg;
  word_t b_reg;
  word_t c_reg;
  word_t d_reg;
  word_t e_reg;

  word_t h0_reg;
  word_t h1_reg;
  word_t h2_reg;
  word_t h3_reg;
  word_t h4_reg;

  word_t f;
  word_t k;
  word_t t;

  assign digest = {h0_reg, h1_reg, h2_reg, h3_reg, h4_reg};

  // ==========================================================================
  // round function
  // ==========================================================================

  always_comb
  begin
    if (round_idx < 7'd20)
    begin
      f = (b_reg & c_reg) | (~b_reg & d_reg);   // choose.
      k = `SHA1_K0;
    end
    else if (round_idx < 7'd40)
    begin
      f = b_reg ^ c_reg ^ d_reg;   // parity.
      k = `SHA1_K1;
    end
    else if (round_idx < 7'd60)
    begin
      f = (b_reg & c_reg) | (b_reg & d_reg) | (c_reg & d_reg);   // majority.
      k = `SHA1_K2;
    end
    else
    begin
      f = b_reg ^ c_reg ^ d_reg;
      k = `SHA1_K3;
    end

    t = {a_reg[26:0], a_reg[31:27]} + f + e_reg + k + w;
  end

  // ==========================================================================
  // working variables
  // ==========================================================================

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      if (first_block)
      begin
        a_reg <= `SHA1_H0;
        b_reg <= `SHA1_H1;
        c_reg <= `SHA1_H2;
        d_reg <= `SHA1_H3;
        e_reg <= `SHA1_H4;
      end
      else
      begin
        // continue the chain.
        a_reg <= h0_reg;
        b_reg <= h1_reg;
        c_reg <= h2_reg;
        d_reg <= h3_reg;
        e_reg <= h4_reg;
      end
    end
    else if (round_en)
    begin
      a_reg <= t;
      b_reg <= a_reg;
      c_reg <= {b_reg[1:0], b_reg[31:2]};   // rotl 30.
      d_reg <= c_reg;
      e_reg <= d_reg;
    end
  end

  // ==========================================================================
  // digest registers
  // ==========================================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      h0_reg <= `SHA1_H0;
      h1_reg <= `SHA1_H1;
      h2_reg <= `SHA1_H2;
      h3_reg <= `SHA1_H3;
      h4_reg <= `SHA1_H4;
    end
    else if (load && first_block)
    begin
      h0_reg <= `SHA1_H0;   // new message.
      h1_reg <= `SHA1_H1;
      h2_reg <= `SHA1_H2;
      h3_reg <= `SHA1_H3;
      h4_reg <= `SHA1_H4;
    end
    else if (update)
    begin
      h0_reg <= h0_reg + a_reg;
      h1_reg <= h1_reg + b_reg;
      h2_reg <= h2_reg + c_reg;
      h3_reg <= h3_reg + d_reg;
      h4_reg <= h4_reg + e_reg;
    end
  end

  // strobes come from separate controller states.
  a_strobe_onehot : assert property (
    @(posedge clk) disable iff (!reset_n)
    $onehot0({load, round_en, update})
  ) else $error("sha1_compress: load, round_en and update overlap.");

endmodule

`default_nettype wire

// File: src/sha1_core.sv
`timescale 1ns/1ps
`default_nettype none

module sha1_core (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              init,
  input  logic              next,
  input  sha1_pkg::block_t  block,
  output logic              ready,
  output logic              digest_valid,
  output sha1_pkg::digest_t digest
);

  import sha1_pkg::*;

  // controller strobes.
  logic   start;
  logic   first_block;
  logic   round_en;
  logic   update;
  round_t round_idx;

  word_t  w;   // schedule word for the current round.

  // ==========================================================================
  // controller
  // ==========================================================================

  sha1_ctrl ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .init         (init),
    .next         (next),
    .start        (start),
    .first_block  (first_block),
    .round_en     (round_en),
    .update       (update),
    .ready        (ready),
    .digest_valid (digest_valid),
    .round_idx    (round_idx)
  );

  // ==========================================================================
  // schedule and datapath
  // ==========================================================================

  sha1_w_mem w_mem_i (
    .clk     (clk),
    .reset_n (reset_n),
    .block   (block),
    .init    (start),
    .next    (round_en),
    .w       (w)
  );

  sha1_compress compress_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .load        (start),
    .first_block (first_block),
    .round_en    (round_en),
    .update      (update),
    .round_idx   (round_idx),
    .w           (w),
    .digest      (digest)
  );

endmodule

`default_nettype wire

// File: bench/sha1_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sha1_settings.svh"

module sha1_core_tb;

  import sha1_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY      = `SHA1_ROUNDS + 1;          // accept edge to ready.
  localparam int OP_CYCLES    = `SHA1_ROUNDS + 1 + 8 + 4;  // worst case per operation.

  localparam int OP_INIT = 0;
  localparam int OP_NEXT = 1;
  localparam int OP_BUSY = 2;   // init with stray pulses during the rounds.

  logic    clk;
  logic    reset_n;
  logic    init;
  logic    next;
  block_t  block;
  logic    ready;
  logic    digest_valid;
  digest_t digest;

  int      op_q[$];
  block_t  block_q[$];
  digest_t expect_q[$];

  int      error_count = 0;
  int      pass_count  = 0;
  int      fail_count  = 0;
  bit      ops_loaded  = 1'b0;
  logic    valid_exp   = 1'b0;   // digest_valid as the core should hold it.

  sha1_core dut_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .init         (init),
    .next         (next),
    .block        (block),
    .ready        (ready),
    .digest_valid (digest_valid),
    .digest       (digest)
  );

  // ==========================================================================
  // clock and watchdog
  // ==========================================================================

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin : watchdog
    int limit;
    wait (ops_loaded);
    limit = op_q.size() * OP_CYCLES + RESET_CYCLES + 4;
    repeat (limit) @(posedge clk);
    $display("timeout: the core gave no result within %0d clock cycles", limit);
    $display("Done: errors found");
    $finish;
  end

  // ==========================================================================
  // compare tasks
  // ==========================================================================

  task automatic check_digest(input string what, input digest_t got, input digest_t exp);
    if (got !== exp)
    begin
      error_count++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      error_count++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    if (got != exp)
    begin
      error_count++;
      $display("error at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  // ==========================================================================
  // vectors and operations
  // ==========================================================================

  // keeps only lines that start with a known keyword.
  task automatic load_vectors();
    int               fd;
    int               n;
    logic [8*256-1:0] line_buf;
    logic [63:0]      kw;
    block_t           blk;
    digest_t          dig;
    fd = $fopen("bench/sha1_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open bench/sha1_input.txt, so no vectors were run");
      error_count++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line_buf = '0;
        kw       = '0;
        n = $fgets(line_buf, fd);
        if (n > 0)
        begin
          n = $sscanf(line_buf, "%s %h %h", kw, blk, dig);
          if (n == 3 && (kw == "init" || kw == "next" || kw == "busy"))
          begin
            op_q.push_back(kw == "init" ? OP_INIT : (kw == "next" ? OP_NEXT : OP_BUSY));
            block_q.push_back(blk);
            expect_q.push_back(dig);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic string op_name(input int op);
    if (op == OP_INIT)
      return "init";
    else if (op == OP_NEXT)
      return "next";
    else
      return "busy";
  endfunction

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before)
    begin
      pass_count++;
      $display("test %s: passed", name);
    end
    else
    begin
      fail_count++;
      $display("test %s: failed", name);
    end
  endtask

  // enters and leaves on a falling edge.
  task automatic run_op(input int idx, input int op, input block_t blk,
                        input digest_t exp, input digest_t held);
    int   cycles;
    int   errors_before;
    errors_before = error_count;
    repeat ($urandom % 8) @(negedge clk);   // idle gap.
    check_digest("held digest", digest, held);
    check_flag("ready before pulse", ready, 1'b1);
    check_flag("digest_valid before pulse", digest_valid, valid_exp);
    block = blk;
    if (op == OP_NEXT)
      next = 1'b1;
    else
      init = 1'b1;
    @(posedge clk);   // accept edge.
    @(negedge clk);
    init = 1'b0;
    next = 1'b0;
    check_flag("ready after accept", ready, 1'b0);
    check_flag("digest_valid after accept", digest_valid,
               (op == OP_NEXT) ? valid_exp : 1'b0);
    cycles = 0;
    while (!ready)
    begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (op == OP_BUSY)
      begin
        case (cycles)
          20: init = 1'b1;
          21: init = 1'b0;
          40:
          begin
            next  = 1'b1;
            block = ~blk;   // must not reach the schedule.
          end
          41: next = 1'b0;
          80: init = 1'b1;   // sampled at the edge where ready rises.
          default: ;
        endcase
      end
    end
    init = 1'b0;
    next = 1'b0;
    check_latency("latency", cycles, LATENCY);
    check_flag("digest_valid when done", digest_valid, 1'b1);
    check_digest("digest", digest, exp);
    valid_exp = 1'b1;
    report_test($sformatf("%0d (%s)", idx, op_name(op)), errors_before);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial
  begin : main
    int      errors_before;
    digest_t held;
    init    = 1'b0;
    next    = 1'b0;
    block   = '0;
    reset_n = 1'b0;
    void'($urandom(32'he15dd1b2));
    load_vectors();
    ops_loaded = 1'b1;

    repeat (RESET_CYCLES) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    held = {`SHA1_H0, `SHA1_H1, `SHA1_H2, `SHA1_H3, `SHA1_H4};
    valid_exp = 1'b0;
    errors_before = error_count;
    check_flag("ready after reset", ready, 1'b1);
    check_flag("digest_valid after reset", digest_valid, 1'b0);
    check_digest("digest after reset", digest, held);
    report_test("0 (reset)", errors_before);

    for (int i = 0; i < op_q.size(); i++)
    begin
      run_op(i + 1, op_q[i], block_q[i], expect_q[i], held);
      held = expect_q[i];
    end

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (error_count == 0 && fail_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/sha1_input.txt
# columns: operation (init, next or busy), 512-bit block in hex with word 0 first,
# and the expected 160-bit digest in hex. busy is an init with stray pulses.

# "abc", one padded block.
init 61626380000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000018 a9993e364706816aba3e25717850c26c9cd0d89d

# 56-character reference message, first block then the chained second block.
init 6162636462636465636465666465666765666768666768696768696a68696a6b696a6b6c6a6b6c6d6b6c6d6e6c6d6e6f6d6e6f706e6f70718000000000000000 f4286818c37b27ae0408f581846771484a566572
next 000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000001c0 84983e441c3bd26ebaae4aa1f95129e5e54670f1

# empty message after a chained one.
init 80000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 da39a3ee5e6b4b0d3255bfef95601890afd80709

# "abc" with pulses injected during the rounds.
busy 61626380000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000018 a9993e364706816aba3e25717850c26c9cd0d89d

# restart from the initial values after finished messages.
init 6162636462636465636465666465666765666768666768696768696a68696a6b696a6b6c6a6b6c6d6b6c6d6e6c6d6e6f6d6e6f706e6f70718000000000000000 f4286818c37b27ae0408f581846771484a566572
next 000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000001c0 84983e441c3bd26ebaae4aa1f95129e5e54670f1
init 80000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 da39a3ee5e6b4b0d3255bfef95601890afd80709
init 61626380000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000018 a9993e364706816aba3e25717850c26c9cd0d89d

// File: sources.f
+incdir+include
src/sha1_pkg.sv
src/sha1_ctrl.sv
src/sha1_w_mem.sv
src/sha1_compress.sv
src/sha1_core.sv
bench/sha1_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SHA-1 core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module sha1_core_tb -f sources.f -o sha1_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

# a crashed or stopped simulation counts as a failure.
./obj_dir/sha1_sim > sim.log 2>&1 || echo "Done: errors found" >> sim.log
cat sim.log

grep -q "Done: errors found" sim.log \
  && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
